// ==== logic/lsu_consts.svh ====
// Load/store path sizing constants
// Data width, data memory depth and byte lane count

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Core data and address width
`define LSU_XLEN        32

// Data memory geometry, 64 words = 256 bytes
`define DMEM_WORDS      64
`define DMEM_WAWIDTH    6   // log2 of DMEM_WORDS

// One bank per byte of a word
`define DMEM_LANES      4

`endif

// ==== logic/lsu_pkg.sv ====
// Load/store path types
// Command, memory and exception encodings plus request/response structs

package lsu_pkg;

`include "lsu_consts.svh"

    // Commands from the execute stage
    typedef enum logic [3:0] {
        LSU_CMD_NONE = 4'd0,
        LSU_CMD_LB   = 4'd1,
        LSU_CMD_LH   = 4'd2,
        LSU_CMD_LW   = 4'd3,
        LSU_CMD_LBU  = 4'd4,
        LSU_CMD_LHU  = 4'd5,
        LSU_CMD_SB   = 4'd6,
        LSU_CMD_SH   = 4'd7,
        LSU_CMD_SW   = 4'd8
    } lsu_cmd_e;

    typedef enum logic {MEM_CMD_RD, MEM_CMD_WR} mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'd0,
        MEM_WIDTH_HWORD = 2'd1,
        MEM_WIDTH_WORD  = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'd0,
        MEM_RESP_RDY_OK = 2'd1,
        MEM_RESP_RDY_ER = 2'd2
    } mem_resp_e;

    // RISC-V mcause numbering for the LSU exceptions
    typedef enum logic [3:0] {
        EXC_CODE_NONE             = 4'd0,
        EXC_CODE_LD_ADDR_MISALIGN = 4'd4,
        EXC_CODE_LD_ACCESS_FAULT  = 4'd5,
        EXC_CODE_ST_ADDR_MISALIGN = 4'd6,
        EXC_CODE_ST_ACCESS_FAULT  = 4'd7
    } exc_code_e;

    typedef struct packed {
        logic                   req;    // Single-cycle strobe
        mem_cmd_e               cmd;
        mem_width_e             width;
        logic [`LSU_XLEN-1:0]   addr;   // Byte address
        logic [`LSU_XLEN-1:0]   wdata;  // Store data, right aligned
    } dmem_req_s;

    typedef struct packed {
        logic                       en;
        logic                       we;
        logic [`DMEM_WAWIDTH-1:0]   widx;   // Word index within bank
        logic [7:0]                 wbyte;
    } lane_req_s;

    typedef struct packed {
        mem_resp_e              resp;
        logic [`LSU_XLEN-1:0]   rdata;  // Shifted down by byte offset
    } dmem_resp_s;

endpackage

// ==== logic/lsu_unit.sv ====
// Load/store unit
// Accepts one execute-stage command at a time, flags misalignment,
// issues to data memory and extends the returned load data

`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_unit import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,

    // Execute stage side
    input  logic                    exu_req,        // Held until rdy or exc
    input  lsu_cmd_e                exu_cmd,
    input  logic [`LSU_XLEN-1:0]    exu_addr,
    input  logic [`LSU_XLEN-1:0]    exu_sdata,
    output logic                    lsu_rdy,
    output logic [`LSU_XLEN-1:0]    lsu_ldata,
    output logic                    lsu_exc,
    output exc_code_e               lsu_exc_code,
    output logic                    lsu_busy,

    // Data memory side
    output dmem_req_s               dmem_req,
    input  dmem_resp_s              dmem_resp
);

    typedef enum logic {ST_IDLE, ST_BUSY} lsu_fsm_e;

    lsu_fsm_e   fsm;
    lsu_cmd_e   lsu_cmd_r;      // Command in flight
    logic       resp_ok;
    logic       resp_er;
    logic       l_misalign;
    logic       s_misalign;

    assign resp_ok = (dmem_resp.resp == MEM_RESP_RDY_OK);
    assign resp_er = (dmem_resp.resp == MEM_RESP_RDY_ER);

    // -------------------------------------------------------------------------
    // FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm       <= ST_IDLE;
            lsu_cmd_r <= LSU_CMD_NONE;
        end else begin
            case (fsm)
                ST_IDLE: begin
                    if (dmem_req.req) begin   // Memory always accepts
                        fsm       <= ST_BUSY;
                        lsu_cmd_r <= exu_cmd;
                    end
                end
                ST_BUSY: begin
                    if (resp_ok || resp_er) fsm <= ST_IDLE;
                end
                default: fsm <= ST_IDLE;
            endcase
        end
    end

    assign lsu_busy = (fsm == ST_BUSY);

    // Misalignment, combinational in the request cycle
    always_comb begin
        l_misalign = 1'b0;
        s_misalign = 1'b0;
        if (exu_req) begin
            case (exu_cmd)
                LSU_CMD_LH,
                LSU_CMD_LHU: l_misalign = exu_addr[0];
                LSU_CMD_LW:  l_misalign = |exu_addr[1:0];
                LSU_CMD_SH:  s_misalign = exu_addr[0];
                LSU_CMD_SW:  s_misalign = |exu_addr[1:0];
                default:     ;                          // Byte ops always aligned
            endcase
        end
    end

    assign lsu_rdy = resp_ok | resp_er;
    assign lsu_exc = resp_er | l_misalign | s_misalign;

    // -------------------------------------------------------------------------
    // Exception code, access fault first
    // -------------------------------------------------------------------------
    always_comb begin
        if (resp_er) begin
            case (lsu_cmd_r)
                LSU_CMD_LB, LSU_CMD_LH, LSU_CMD_LW,
                LSU_CMD_LBU, LSU_CMD_LHU: lsu_exc_code = EXC_CODE_LD_ACCESS_FAULT;
                LSU_CMD_SB, LSU_CMD_SH,
                LSU_CMD_SW:               lsu_exc_code = EXC_CODE_ST_ACCESS_FAULT;
                default:                  lsu_exc_code = EXC_CODE_NONE;   // Not reachable
            endcase
        end else if (l_misalign) begin
            lsu_exc_code = EXC_CODE_LD_ADDR_MISALIGN;
        end else if (s_misalign) begin
            lsu_exc_code = EXC_CODE_ST_ADDR_MISALIGN;
        end else begin
            lsu_exc_code = EXC_CODE_NONE;
        end
    end

    // Load extension, rdata already shifted to bit 0
    always_comb begin
        case (lsu_cmd_r)
            LSU_CMD_LW:  lsu_ldata = dmem_resp.rdata;
            LSU_CMD_LH:  lsu_ldata = {{16{dmem_resp.rdata[15]}}, dmem_resp.rdata[15:0]};
            LSU_CMD_LHU: lsu_ldata = {16'h0000, dmem_resp.rdata[15:0]};
            LSU_CMD_LB:  lsu_ldata = {{24{dmem_resp.rdata[7]}}, dmem_resp.rdata[7:0]};
            LSU_CMD_LBU: lsu_ldata = {24'h000000, dmem_resp.rdata[7:0]};
            default:     lsu_ldata = '0;
        endcase
    end

    // -------------------------------------------------------------------------
    // Memory request
    // -------------------------------------------------------------------------
    always_comb begin
        dmem_req.req   = exu_req & ~l_misalign & ~s_misalign & (fsm == ST_IDLE);
        dmem_req.addr  = exu_addr;
        dmem_req.wdata = exu_sdata;
        case (exu_cmd)
            LSU_CMD_SB, LSU_CMD_SH, LSU_CMD_SW: dmem_req.cmd = MEM_CMD_WR;
            default:                            dmem_req.cmd = MEM_CMD_RD;
        endcase
        case (exu_cmd)
            LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_SB: dmem_req.width = MEM_WIDTH_BYTE;
            LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH: dmem_req.width = MEM_WIDTH_HWORD;
            default:                             dmem_req.width = MEM_WIDTH_WORD;
        endcase
    end

endmodule

// ==== logic/dmem_lane_steer.sv ====
// Data memory lane steering
// Range check, byte enable decode and store data placement per lane,
// plus the registered context for the response merge

`timescale 1ns/1ps
`include "lsu_consts.svh"

module dmem_lane_steer import lsu_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  dmem_req_s                           dmem_req,
    output lane_req_s [`DMEM_LANES-1:0]         lane_req,
    output logic                                ctx_valid,
    output logic                                ctx_fault,
    output logic [1:0]                          ctx_offset,
    output mem_width_e                          ctx_width
);

    logic [1:0]                 offset;
    logic                       in_range;
    logic [`DMEM_LANES-1:0]     byte_en;
    logic [`LSU_XLEN-1:0]       wdata_sh;   // Store data moved to its lanes

    assign offset   = dmem_req.addr[1:0];
    assign in_range = (dmem_req.addr[`LSU_XLEN-1:2] < `DMEM_WORDS);
    assign wdata_sh = dmem_req.wdata << {offset, 3'b000};

    always_comb begin
        case (dmem_req.width)
            MEM_WIDTH_BYTE:  byte_en = 4'b0001 << offset;
            MEM_WIDTH_HWORD: byte_en = 4'b0011 << offset;
            default:         byte_en = 4'b1111;
        endcase
    end

    // Per-lane request, nothing enabled when out of range
    always_comb begin
        for (int i = 0; i < `DMEM_LANES; i++) begin
            lane_req[i].en    = dmem_req.req & in_range & byte_en[i];
            lane_req[i].we    = (dmem_req.cmd == MEM_CMD_WR);
            lane_req[i].widx  = dmem_req.addr[`DMEM_WAWIDTH+1:2];
            lane_req[i].wbyte = wdata_sh[8*i +: 8];
        end
    end

    // -------------------------------------------------------------------------
    // Response context, one cycle behind the strobe
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx_valid <= 1'b0;
            ctx_fault <= 1'b0;
        end else begin
            ctx_valid <= dmem_req.req;
            ctx_fault <= dmem_req.req & ~in_range;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_req.req) begin
            ctx_offset <= offset;
            ctx_width  <= dmem_req.width;
        end
    end

endmodule

// ==== logic/dmem_byte_bank.sv ====
// One byte lane of the data memory
// Synchronous write, registered read with one cycle latency

`timescale 1ns/1ps
`include "lsu_consts.svh"

module dmem_byte_bank import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  lane_req_s   lane_req,
    output logic [7:0]  rbyte
);

    logic [7:0] mem [`DMEM_WORDS];     // Lane storage

    always_ff @(posedge clk) begin
        if (lane_req.en && lane_req.we) begin
            mem[lane_req.widx] <= lane_req.wbyte;
        end
    end

    // Read register holds its value between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rbyte <= 8'h00;
        end else if (lane_req.en && !lane_req.we) begin
            rbyte <= mem[lane_req.widx];
        end
    end

endmodule

// ==== logic/dmem_resp_merge.sv ====
// Data memory response merge
// Joins the lane bytes, aligns them to bit 0 and forms the response code

`timescale 1ns/1ps
`include "lsu_consts.svh"

module dmem_resp_merge import lsu_pkg::*; (
    input  logic                    ctx_valid,
    input  logic                    ctx_fault,
    input  logic [1:0]              ctx_offset,
    input  mem_width_e              ctx_width,
    input  logic [`LSU_XLEN-1:0]    rbytes,     // Lane 0 in bits 7:0
    output dmem_resp_s              dmem_resp
);

    logic [`LSU_XLEN-1:0] word_sh;
    logic [`LSU_XLEN-1:0] width_mask;

    // Addressed byte down to bit 0
    assign word_sh = rbytes >> {ctx_offset, 3'b000};

    always_comb begin
        case (ctx_width)
            MEM_WIDTH_BYTE:  width_mask = 32'h0000_00ff;
            MEM_WIDTH_HWORD: width_mask = 32'h0000_ffff;
            default:         width_mask = 32'hffff_ffff;
        endcase
    end

    // -------------------------------------------------------------------------
    // Response
    // -------------------------------------------------------------------------
    always_comb begin
        if (!ctx_valid) begin
            dmem_resp.resp = MEM_RESP_IDLE;
        end else if (ctx_fault) begin
            dmem_resp.resp = MEM_RESP_RDY_ER;   // Outside the memory
        end else begin
            dmem_resp.resp = MEM_RESP_RDY_OK;
        end
        // No data leaks out on a fault
        dmem_resp.rdata = ctx_fault ? '0 : (word_sh & width_mask);
    end

endmodule

// ==== logic/lsu_dmem_top.sv ====
// Load/store path top level
// LSU in front of a four-lane byte-banked data memory

`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_dmem_top import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    exu_req,
    input  lsu_cmd_e                exu_cmd,
    input  logic [`LSU_XLEN-1:0]    exu_addr,
    input  logic [`LSU_XLEN-1:0]    exu_sdata,
    output logic                    lsu_rdy,
    output logic [`LSU_XLEN-1:0]    lsu_ldata,
    output logic                    lsu_exc,
    output exc_code_e               lsu_exc_code,
    output logic                    lsu_busy
);

    dmem_req_s                      dmem_req;
    dmem_resp_s                     dmem_resp;
    lane_req_s [`DMEM_LANES-1:0]    lane_req;
    logic [`LSU_XLEN-1:0]           rbytes;     // All lane read bytes
    logic                           ctx_valid;
    logic                           ctx_fault;
    logic [1:0]                     ctx_offset;
    mem_width_e                     ctx_width;

    lsu_unit lsu_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .exu_req      (exu_req),
        .exu_cmd      (exu_cmd),
        .exu_addr     (exu_addr),
        .exu_sdata    (exu_sdata),
        .lsu_rdy      (lsu_rdy),
        .lsu_ldata    (lsu_ldata),
        .lsu_exc      (lsu_exc),
        .lsu_exc_code (lsu_exc_code),
        .lsu_busy     (lsu_busy),
        .dmem_req     (dmem_req),
        .dmem_resp    (dmem_resp)
    );

    dmem_lane_steer dmem_lane_steer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_req   (dmem_req),
        .lane_req   (lane_req),
        .ctx_valid  (ctx_valid),
        .ctx_fault  (ctx_fault),
        .ctx_offset (ctx_offset),
        .ctx_width  (ctx_width)
    );

    // -------------------------------------------------------------------------
    // Byte banks
    // -------------------------------------------------------------------------
    for (genvar i = 0; i < `DMEM_LANES; i++) begin : g_bank
        dmem_byte_bank dmem_byte_bank_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .lane_req (lane_req[i]),
            .rbyte    (rbytes[8*i +: 8])
        );
    end

    dmem_resp_merge dmem_resp_merge_i (
        .ctx_valid  (ctx_valid),
        .ctx_fault  (ctx_fault),
        .ctx_offset (ctx_offset),
        .ctx_width  (ctx_width),
        .rbytes     (rbytes),
        .dmem_resp  (dmem_resp)
    );

endmodule

// ==== bench/lsu_clkgen.sv ====
// Testbench clock and reset
// 100 ns clock, reset held low for the first 4 cycles

`timescale 1ns/1ps

module lsu_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #5 rst_n = 1'b1;            // Released off the edge
    end

endmodule

// ==== bench/lsu_properties.sv ====
// Load/store path timing properties
// Strobe to ready latency, busy window and exception qualification

`timescale 1ns/1ps

module lsu_properties (
    input logic clk,
    input logic rst_n,
    input logic exu_req,
    input logic strobe,         // Memory request strobe from the LSU
    input logic lsu_rdy,
    input logic lsu_exc,
    input logic lsu_busy
);

    int fail_count = 0;         // Property failures so far

    // ------------------------------------------------------------------------
    // Memory handshake timing
    // ------------------------------------------------------------------------
    a_rdy_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        strobe |=> lsu_rdy)
        else begin
            $error("No ready one cycle after a memory strobe");
            fail_count++;
        end

    a_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rdy |=> !lsu_rdy)
        else begin
            $error("Ready held for more than one cycle");
            fail_count++;
        end

    // Busy covers exactly the cycle after the strobe
    a_busy_window: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_busy |-> $past(strobe))
        else begin
            $error("Busy without a strobe in the previous cycle");
            fail_count++;
        end

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_busy |-> !strobe)
        else begin
            $error("Memory strobe issued while busy");
            fail_count++;
        end

    a_no_rdy_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !lsu_busy |-> !lsu_rdy)
        else begin
            $error("Ready while the LSU is idle");
            fail_count++;
        end

    // Exceptions only against a live request
    a_exc_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_exc |-> exu_req)
        else begin
            $error("Exception without an execute request");
            fail_count++;
        end

endmodule

// ==== bench/lsu_tb.sv ====
// Load/store path testbench
// Random stores and loads against a byte model, plus misaligned and fault cases

`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb import lsu_pkg::*; ();

    logic                   clk;
    logic                   rst_n;
    logic                   exu_req;
    lsu_cmd_e               exu_cmd;
    logic [`LSU_XLEN-1:0]   exu_addr;
    logic [`LSU_XLEN-1:0]   exu_sdata;
    logic                   lsu_rdy;
    logic [`LSU_XLEN-1:0]   lsu_ldata;
    logic                   lsu_exc;
    exc_code_e              lsu_exc_code;
    logic                   lsu_busy;

    logic [7:0]             ref_mem [4*`DMEM_WORDS];    // Byte model
    logic [31:0]            lcg_state = 32'h07f7_3acd;

    lsu_clkgen lsu_clkgen_i (.clk(clk), .rst_n(rst_n));

    lsu_dmem_top lsu_dmem_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .exu_req      (exu_req),
        .exu_cmd      (exu_cmd),
        .exu_addr     (exu_addr),
        .exu_sdata    (exu_sdata),
        .lsu_rdy      (lsu_rdy),
        .lsu_ldata    (lsu_ldata),
        .lsu_exc      (lsu_exc),
        .lsu_exc_code (lsu_exc_code),
        .lsu_busy     (lsu_busy)
    );

    bind lsu_dmem_top lsu_properties lsu_properties_i (
        .clk(clk), .rst_n(rst_n), .exu_req(exu_req), .strobe(dmem_req.req),
        .lsu_rdy(lsu_rdy), .lsu_exc(lsu_exc), .lsu_busy(lsu_busy)
    );

    // Stop at the first timing property failure
    always @(negedge clk) begin
        if (lsu_dmem_top_i.lsu_properties_i.fail_count != 0) begin
            $display("Timing property violated at %0t ns", $time);
            $display("TEST FAILED");
            $fatal(1, "Property failure");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "Check failed");
    endtask

    function automatic int access_size(input lsu_cmd_e cmd);
        case (cmd)
            LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_SB: return 1;
            LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH: return 2;
            default:                             return 4;
        endcase
    endfunction

    function automatic bit is_store(input lsu_cmd_e cmd);
        return (cmd == LSU_CMD_SB) || (cmd == LSU_CMD_SH) || (cmd == LSU_CMD_SW);
    endfunction

    // Little-endian bytes from the model, extended per RISC-V load rules
    function automatic logic [31:0] expected_load(input lsu_cmd_e cmd, input int a);
        case (cmd)
            LSU_CMD_LB:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
            LSU_CMD_LBU: return {24'h0, ref_mem[a]};
            LSU_CMD_LH:  return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            LSU_CMD_LHU: return {16'h0, ref_mem[a+1], ref_mem[a]};
            default:     return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // One access: hold the request until ready or exception, then check
    // ------------------------------------------------------------------------
    task automatic issue_and_check(input lsu_cmd_e cmd, input logic [31:0] addr,
                                   input logic [31:0] sdata);
        int         n;
        int         size;
        bit         done;
        bit         misal;
        bit         fault;
        logic       got_rdy;
        logic       got_exc;
        logic       got_busy;
        exc_code_e  got_code;
        logic [31:0] got_ldata;
        size  = access_size(cmd);
        misal = (size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00);
        fault = !misal && (addr >= 4 * `DMEM_WORDS);
        @(posedge clk);
        #5;
        exu_req   = 1'b1;
        exu_cmd   = cmd;
        exu_addr  = addr;
        exu_sdata = sdata;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);             // Mid-cycle sample
            n++;
            if (lsu_rdy || lsu_exc) begin
                done = 1'b1;
            end else if (n >= 10) begin
                $display("Timeout: no ready or exception within 10 cycles, addr %h", addr);
                $display("TEST FAILED");
                $fatal(1, "Timeout");
            end
        end
        got_rdy   = lsu_rdy;
        got_exc   = lsu_exc;
        got_busy  = lsu_busy;
        got_code  = lsu_exc_code;
        got_ldata = lsu_ldata;
        @(posedge clk);
        #5;
        exu_req = 1'b0;
        exu_cmd = LSU_CMD_NONE;
        if (misal) begin
            // Rejected in the request cycle, nothing sent to memory
            assert (n == 1 && got_exc && !got_rdy)
                else stop_on_error($sformatf("no misalign exception at addr %h", addr));
            assert (got_code == (is_store(cmd) ? EXC_CODE_ST_ADDR_MISALIGN
                                               : EXC_CODE_LD_ADDR_MISALIGN))
                else stop_on_error($sformatf("misalign code %0d at addr %h", got_code, addr));
        end else begin
            assert (n == 2 && got_rdy && got_busy)
                else stop_on_error($sformatf("ready after %0d cycles at addr %h", n, addr));
            if (fault) begin
                assert (got_exc && got_code == (is_store(cmd) ? EXC_CODE_ST_ACCESS_FAULT
                                                              : EXC_CODE_LD_ACCESS_FAULT))
                    else stop_on_error($sformatf("fault code %0d at addr %h", got_code, addr));
            end else begin
                assert (!got_exc)
                    else stop_on_error($sformatf("unexpected exception at addr %h", addr));
                if (is_store(cmd)) begin
                    for (int i = 0; i < size; i++) ref_mem[addr + i] = sdata[8*i +: 8];
                end else begin
                    assert (got_ldata == expected_load(cmd, addr))
                        else stop_on_error($sformatf("load %h at addr %h, expected %h",
                                           got_ldata, addr, expected_load(cmd, addr)));
                end
            end
        end
    endtask

    initial begin
        int n;
        exu_req   = 1'b0;
        exu_cmd   = LSU_CMD_NONE;
        exu_addr  = '0;
        exu_sdata = '0;
        n = 0;
        // Look at reset only on clock edges
        do begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                $display("Reset never released");
                $display("TEST FAILED");
                $fatal(1, "Reset timeout");
            end
        end while (!rst_n);

        // Word round trip, also fills the whole memory
        for (int w = 0; w < `DMEM_WORDS; w++) issue_and_check(LSU_CMD_SW, 4*w, lcg_next());
        foreach (ref_mem[a]) if (a % 68 == 0) issue_and_check(LSU_CMD_LW, a, 0);

        // Byte and halfword loads at every offset
        for (int a = 32; a < 48; a++) begin
            issue_and_check(LSU_CMD_LB, a, 0);
            issue_and_check(LSU_CMD_LBU, a, 0);
            if (a % 2 == 0) begin
                issue_and_check(LSU_CMD_LH, a, 0);
                issue_and_check(LSU_CMD_LHU, a, 0);
            end
        end

        // Partial stores, checked by word loads
        for (int a = 64; a < 80; a++) begin
            issue_and_check(LSU_CMD_SB, a, lcg_next());
            if (a % 2 == 0) issue_and_check(LSU_CMD_SH, a + 16, lcg_next());
            if (a % 4 == 3) issue_and_check(LSU_CMD_LW, a - 3, 0);
        end

        // Misaligned accesses
        issue_and_check(LSU_CMD_LH, 101, 0);
        issue_and_check(LSU_CMD_LHU, 103, 0);
        issue_and_check(LSU_CMD_LW, 102, 0);
        issue_and_check(LSU_CMD_LW, 101, 0);
        issue_and_check(LSU_CMD_SH, 105, lcg_next());
        issue_and_check(LSU_CMD_SW, 106, lcg_next());
        issue_and_check(LSU_CMD_SW, 107, lcg_next());

        // Outside the memory, 256 would alias word 0 without the range check
        issue_and_check(LSU_CMD_LW, 4*`DMEM_WORDS, 0);
        issue_and_check(LSU_CMD_LB, 300, 0);
        issue_and_check(LSU_CMD_LHU, 32'hffff_fffe, 0);
        issue_and_check(LSU_CMD_SW, 4*`DMEM_WORDS, lcg_next());
        issue_and_check(LSU_CMD_SB, 4*`DMEM_WORDS + 1, lcg_next());
        issue_and_check(LSU_CMD_SH, 32'h0000_1000, lcg_next());

        // Whole memory must still match the model
        for (int w = 0; w < `DMEM_WORDS; w++) issue_and_check(LSU_CMD_LW, 4*w, 0);

        @(negedge clk);     // Let the last properties settle
        if (lsu_dmem_top_i.lsu_properties_i.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Property failure");
        end
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_unit.sv
logic/dmem_lane_steer.sv
logic/dmem_byte_bank.sv
logic/dmem_resp_merge.sv
logic/lsu_dmem_top.sv
bench/lsu_clkgen.sv
bench/lsu_properties.sv
bench/lsu_tb.sv
